/* flist.f */
+incdir+dv
source/ks10BusPkg.sv
source/ks10ClockPkg.sv
source/phaseSequencer.sv
source/busArbiter.sv
source/busCycleLatch.sv
source/mainMemory.sv
source/ks10Backplane.sv
dv/ks10BackplaneTb.sv

/* Bender.yml */
package:
  name: ks10backplane

sources:
  - source/ks10BusPkg.sv
  - source/ks10ClockPkg.sv
  - source/phaseSequencer.sv
  - source/busArbiter.sv
  - source/busCycleLatch.sv
  - source/mainMemory.sv
  - source/ks10Backplane.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ks10BackplaneTb.sv

/* dv/tbBusTasks.svh */
// Included inside the testbench module and uses its bus signals, refMem, lastAck and cycleCount

// Reference model keeps only the low address bits, as the memory does
task automatic recordWrite(input ks10BusPkg::busAddrT addr, input ks10BusPkg::busWordT data);
   refMem[addr % MemWords] = data;
endtask

// One bus transaction as a single master, called on a rising edge
task automatic busTransfer(
   input  int                  master,
   input  logic                isWrite,
   input  ks10BusPkg::busAddrT addr,
   input  ks10BusPkg::busWordT wdata,
   output ks10BusPkg::busWordT rdata
);
   busReq[master]    <= 1'b1;
   busWrite[master]  <= isWrite;
   busAddr[master]   <= addr;
   busDataIn[master] <= wdata;
   do
      @(posedge clkT);
   while (!busAck[master]);        // Ack of the cycle just ended
   rdata = busDataOut;             // Valid in the ack cycle
   lastAck[master] = cycleCount;
   busReq[master] <= 1'b0;
   if (isWrite)
      recordWrite(addr, wdata);
endtask

task automatic checkRead(input string testName, input int master, input ks10BusPkg::busAddrT addr);
   ks10BusPkg::busWordT rdata;
   ks10BusPkg::busWordT expected;
   expected = refMem[addr % MemWords];
   busTransfer(master, 1'b0, addr, '0, rdata);
   assert (rdata === expected)
   else reportMismatch(testName, expected, rdata);
endtask

/* dv/ks10BackplaneTb.sv */
// Runs the default three masters and 1024 words; only written addresses are ever read back
`default_nettype none
`timescale 1ns/10ps

module ks10BackplaneTb;

   localparam int NumMasters = ks10BusPkg::DefNumMasters;
   localparam int MemWords   = ks10BusPkg::DefMemWords;
   localparam int RandWords  = 40;
   localparam int PlannedTx  = 2 + 2 * RandWords + 5 + 2;
   localparam int CycleLimit = 16 + 4 * PlannedTx * 2 + 64;

   logic                                 clkT = 1'b0;
   logic                                 memRST;
   logic [NumMasters-1:0]                busReq;
   logic [NumMasters-1:0]                busWrite;
   ks10BusPkg::busAddrT [NumMasters-1:0] busAddr;
   ks10BusPkg::busWordT [NumMasters-1:0] busDataIn;
   logic [NumMasters-1:0]                busAck;
   ks10BusPkg::busWordT                  busDataOut;
   ks10ClockPkg::phaseT                  clkPhase;
   logic                                 sysReset;

   int                  valueErrors = 0;
   int                  otherErrors = 0;
   int                  cycleCount  = 0;
   int                  runCycles   = 0;    // Cycles since memRST fell
   int                  seed;
   ks10BusPkg::busWordT refMem [MemWords];
   int                  lastAck [NumMasters];
   ks10BusPkg::busAddrT randAddr [RandWords];

   task automatic reportMismatch(input string testName, input logic [63:0] expected,
                                 input logic [63:0] actual);
      valueErrors++;
      $display("Error %s expected %h actual %h", testName, expected, actual);
   endtask

   task automatic reportFailure(input string what);
      otherErrors++;
      $display("Failure: %s", what);
   endtask

   // Phase of a given cycle counted from the first cycle with memRST low
   function automatic ks10ClockPkg::phaseT phaseAt(input int runCycle);
      case (runCycle % 4)
         0:       return ks10ClockPkg::T1;
         1:       return ks10ClockPkg::T2;
         2:       return ks10ClockPkg::T3;
         default: return ks10ClockPkg::T4;
      endcase
   endfunction

   `include "tbBusTasks.svh"

   ks10Backplane #(
      .NumMasters (NumMasters),
      .MemWords   (MemWords)
   ) dut (
      .clkT       (clkT),
      .memRST     (memRST),
      .busReq     (busReq),
      .busWrite   (busWrite),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut),
      .clkPhase   (clkPhase),
      .sysReset   (sysReset)
   );

   always #4 clkT = ~clkT;   // 8 ns period

   //////////////////////////////
   // History and timeout
   //////////////////////////////

   always @(posedge clkT)
   begin
      runCycles  <= memRST ? 0 : runCycles + 1;
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit)
      begin
         $display("Timeout: bus transactions still pending after %0d cycles", cycleCount);
         $display("Done: errors found");
         $finish;
      end
   end

   //////////////////////////////
   // Protocol checks
   //////////////////////////////

   aResetState: assert property (@(posedge clkT) (cycleCount > 0 && memRST) |->
         (busAck == '0 && sysReset && clkPhase == ks10ClockPkg::T1))
      else reportFailure("bus not idle or phase not parked in T1 during reset");
   aPhaseStep: assert property (@(posedge clkT) !memRST |-> clkPhase == phaseAt(runCycles))
      else reportMismatch("phaseStep", phaseAt($sampled(runCycles)), $sampled(clkPhase));
   aSysRelease: assert property (@(posedge clkT) !memRST |-> sysReset == (runCycles < 4))
      else reportMismatch("sysResetRelease", $sampled(runCycles) < 4, $sampled(sysReset));
   aAckOneHot: assert property (@(posedge clkT) cycleCount > 0 |-> $onehot0(busAck))
      else reportFailure("more than one acknowledge bit set");
   aAckPulse: assert property (@(posedge clkT) busAck != '0 |->
         clkPhase == ks10ClockPkg::T4 ##1 busAck == '0)
      else reportFailure("acknowledge outside T4 or longer than one cycle");

   // Winner of a T1 arbitration sees its ack three cycles later
   for (genvar i = 0; i < NumMasters; i++)
   begin : gAckLatency
      aLatency: assert property (@(posedge clkT)
            (clkPhase == ks10ClockPkg::T1 && !sysReset && busReq[i] &&
             (busReq & NumMasters'((1 << i) - 1)) == '0) |->
            ##3 (busAck == NumMasters'(1 << i)))
         else reportFailure($sformatf("master %0d not acknowledged three cycles after T1", i));
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      ks10BusPkg::busWordT rdA;
      ks10BusPkg::busWordT rdB;
      ks10BusPkg::busWordT rdC;
      ks10BusPkg::busWordT wData;
      int                  txStart;
      seed      = 32'h3311bcbb;
      memRST    = 1'b1;
      busReq    = '0;
      busWrite  = '0;
      busAddr   = '0;
      busDataIn = '0;
      repeat (16) @(posedge clkT);
      memRST <= 1'b0;
      do
         @(posedge clkT);
      while (sysReset);

      busTransfer(2, 1'b1, 20'h00042, 36'h123456789, rdA);   // Write by one master
      checkRead("writeRead", 0, 20'h00042);                   // Read by another

      for (int i = 0; i < RandWords; i++)
      begin
         randAddr[i] = ks10BusPkg::busAddrT'($random(seed));
         wData = ks10BusPkg::busWordT'({$random(seed), $random(seed)});
         busTransfer(i % NumMasters, 1'b1, randAddr[i], wData, rdA);
      end
      for (int i = 0; i < RandWords; i++)
         checkRead("randomRead", (i + 1) % NumMasters, randAddr[i]);

      // Same T1 request from masters 1 and 2
      txStart = cycleCount;   // Requests enter T1 and each bus cycle takes four edges
      fork
         busTransfer(1, 1'b1, 20'h00100, 36'h000000111, rdA);
         busTransfer(2, 1'b1, 20'h00200, 36'h000000222, rdB);
      join
      assert (lastAck[1] == txStart + 4)
      else reportMismatch("priorityPair1", txStart + 4, lastAck[1]);
      assert (lastAck[2] == txStart + 8)
      else reportMismatch("priorityPair2", txStart + 8, lastAck[2]);

      txStart = cycleCount;
      fork
         busTransfer(0, 1'b1, 20'h00300, 36'h000000333, rdA);
         busTransfer(1, 1'b1, 20'h00301, 36'h000000444, rdB);
         busTransfer(2, 1'b1, 20'h00302, 36'h000000555, rdC);
      join
      assert (lastAck[0] == txStart + 4)
      else reportMismatch("priorityAll0", txStart + 4, lastAck[0]);
      assert (lastAck[1] == txStart + 8)
      else reportMismatch("priorityAll1", txStart + 8, lastAck[1]);
      assert (lastAck[2] == txStart + 12)
      else reportMismatch("priorityAll2", txStart + 12, lastAck[2]);

      // Address above the array folds onto its low bits
      wData = 36'hA5A5A5A5A;
      busTransfer(1, 1'b1, ks10BusPkg::busAddrT'(20'h00155 + MemWords), wData, rdA);
      busTransfer(0, 1'b0, 20'h00155, '0, rdA);
      assert (rdA === wData)
      else reportMismatch("alias", wData, rdA);

      repeat (4) @(posedge clkT);
      $display("Summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* source/ks10Backplane.sv */
// Masters must hold request fields until their busAck pulse; there is no bus timeout or error path
`default_nettype none
`timescale 1ns/10ps

module ks10Backplane
#(
   parameter int NumMasters = ks10BusPkg::DefNumMasters,
   parameter int MemWords   = ks10BusPkg::DefMemWords
)
(
   input  logic                                    clkT,
   input  logic                                    memRST,
   input  logic [NumMasters-1:0]                   busReq,
   input  logic [NumMasters-1:0]                   busWrite,
   input  ks10BusPkg::busAddrT [NumMasters-1:0]    busAddr,
   input  ks10BusPkg::busWordT [NumMasters-1:0]    busDataIn,
   output logic [NumMasters-1:0]                   busAck,
   output ks10BusPkg::busWordT                     busDataOut,
   output ks10ClockPkg::phaseT                     clkPhase,
   output logic                                    sysReset
);

   localparam int IdxWidth = $clog2(NumMasters);

   logic [IdxWidth-1:0] grantIdx;
   logic                cycleLoad;
   logic                memStrobe;
   ks10BusPkg::busAddrT cycleAddr;   // Latched request
   ks10BusPkg::busWordT cycleData;
   logic                cycleWrite;

   //////////////////////////////
   // Clock phases and reset
   //////////////////////////////

   phaseSequencer uSeq (
      .clkT      (clkT),
      .memRST    (memRST),
      .phase     (clkPhase),
      .sysReset  (sysReset)
   );

   //////////////////////////////
   // Bus control and data path
   //////////////////////////////

   busArbiter #(
      .NumMasters (NumMasters)
   ) uArb (
      .clkT      (clkT),
      .memRST    (memRST),
      .phase     (clkPhase),
      .sysReset  (sysReset),
      .busReq    (busReq),
      .grantIdx  (grantIdx),
      .cycleLoad (cycleLoad),
      .memStrobe (memStrobe),
      .busAck    (busAck)
   );

   busCycleLatch #(
      .NumMasters (NumMasters)
   ) uLatch (
      .clkT       (clkT),
      .memRST     (memRST),
      .cycleLoad  (cycleLoad),
      .grantIdx   (grantIdx),
      .busWrite   (busWrite),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .cycleAddr  (cycleAddr),
      .cycleData  (cycleData),
      .cycleWrite (cycleWrite)
   );

   // Read data goes straight out to all masters
   mainMemory #(
      .MemWords (MemWords)
   ) uMem (
      .clkT       (clkT),
      .memStrobe  (memStrobe),
      .cycleAddr  (cycleAddr),
      .cycleData  (cycleData),
      .cycleWrite (cycleWrite),
      .readData   (busDataOut)
   );

endmodule

`default_nettype wire

/* source/mainMemory.sv */
// MemWords must be a power of two; upper address bits are ignored and contents start undefined
`default_nettype none
`timescale 1ns/10ps

module mainMemory
#(
   parameter int MemWords = 1024
)
(
   input  logic                clkT,
   input  logic                memStrobe,   // One access, asserted in T3
   input  ks10BusPkg::busAddrT cycleAddr,
   input  ks10BusPkg::busWordT cycleData,
   input  logic                cycleWrite,
   output ks10BusPkg::busWordT readData     // Valid in T4, held until next read
);

   localparam int MemAddrWidth = $clog2(MemWords);

   ks10BusPkg::busWordT     memArray [MemWords];
   logic [MemAddrWidth-1:0] wordIdx;

   // Low bits only, so addresses alias every MemWords
   assign wordIdx = cycleAddr[MemAddrWidth-1:0];

   //////////////////////////////
   // Array access
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memStrobe)
      begin
         if (cycleWrite)
            memArray[wordIdx] <= cycleData;
         else
            readData <= memArray[wordIdx];   // Writes leave readData alone
      end
   end

endmodule

`default_nettype wire

/* source/busCycleLatch.sv */
// Inputs are sampled only on the edge ending the T1 load cycle; later changes are ignored
`default_nettype none
`timescale 1ns/10ps

module busCycleLatch
#(
   parameter int NumMasters = 3
)
(
   input  logic                                    clkT,
   input  logic                                    memRST,
   input  logic                                    cycleLoad,   // Capture strobe
   input  logic [$clog2(NumMasters)-1:0]           grantIdx,    // Selected master
   input  logic [NumMasters-1:0]                   busWrite,
   input  ks10BusPkg::busAddrT [NumMasters-1:0]    busAddr,
   input  ks10BusPkg::busWordT [NumMasters-1:0]    busDataIn,
   output ks10BusPkg::busAddrT                     cycleAddr,   // Held T2 to T4
   output ks10BusPkg::busWordT                     cycleData,
   output logic                                    cycleWrite
);

   //////////////////////////////
   // Control bit
   //////////////////////////////

   // A stray strobe after reset must not turn into a write
   always_ff @(posedge clkT)
   begin
      if (memRST)
         cycleWrite <= 1'b0;
      else if (cycleLoad)
         cycleWrite <= busWrite[grantIdx];
   end

   //////////////////////////////
   // Address and data
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (cycleLoad)
      begin
         cycleAddr <= busAddr[grantIdx];     // Winner's address
         cycleData <= busDataIn[grantIdx];   // Unused on reads
      end
   end

endmodule

`default_nettype wire

/* source/busArbiter.sv */
// Fixed priority with index 0 highest, so a busy low index can starve the others
`default_nettype none
`timescale 1ns/10ps

module busArbiter
#(
   parameter int NumMasters = 3
)
(
   input  logic                            clkT,
   input  logic                            memRST,
   input  ks10ClockPkg::phaseT             phase,      // Bus phase
   input  logic                            sysReset,   // Blocks arbitration
   input  logic [NumMasters-1:0]           busReq,     // Level requests
   output logic [$clog2(NumMasters)-1:0]   grantIdx,   // Master being served
   output logic                            cycleLoad,  // Latch strobe in T1
   output logic                            memStrobe,  // Memory access in T3
   output logic [NumMasters-1:0]           busAck      // One-cycle pulse in T4
);

   localparam int IdxWidth = $clog2(NumMasters);

   logic                isT1;
   logic                isT3;
   logic                isT4;
   logic                cycleActive;   // Bus cycle in progress
   logic [IdxWidth-1:0] grantReg;      // Winner of the last arbitration
   logic [IdxWidth-1:0] pickIdx;       // Lowest requesting index

   assign isT1 = (phase == ks10ClockPkg::T1);
   assign isT3 = (phase == ks10ClockPkg::T3);
   assign isT4 = (phase == ks10ClockPkg::T4);

   //////////////////////////////
   // Priority pick
   //////////////////////////////

   // Scan down so the lowest index wins
   always_comb
   begin
      pickIdx = '0;
      for (int i = NumMasters - 1; i >= 0; i--)
      begin
         if (busReq[i])
            pickIdx = IdxWidth'(i);
      end
   end

   assign cycleLoad = isT1 && !sysReset && (|busReq);

   // Latch needs the winner during T1 itself, before grantReg updates
   assign grantIdx = cycleLoad ? pickIdx : grantReg;

   //////////////////////////////
   // Cycle state
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         cycleActive <= 1'b0;
         grantReg    <= '0;
      end
      else if (cycleLoad)
      begin
         cycleActive <= 1'b1;
         grantReg    <= pickIdx;
      end
      else if (isT4)
         cycleActive <= 1'b0;   // Cycle ends with the acknowledge
   end

   assign memStrobe = cycleActive && isT3;

   always_comb
   begin
      busAck = '0;
      if (cycleActive && isT4)
         busAck[grantReg] = 1'b1;
   end

endmodule

`default_nettype wire

/* source/phaseSequencer.sv */
// memRST is synchronous to clkT; an illegal phase code recovers to T1 on the next edge
`default_nettype none
`timescale 1ns/10ps

module phaseSequencer
(
   input  logic                clkT,      // Bus clock
   input  logic                memRST,    // Synchronous reset
   output ks10ClockPkg::phaseT phase,     // Current bus phase
   output logic                sysReset   // Held until first full rotation
);

   //////////////////////////////
   // Phase rotation
   //////////////////////////////

   always_ff @(posedge clkT)
   begin
      if (memRST)
      begin
         phase    <= ks10ClockPkg::T1;  // Park in T1
         sysReset <= 1'b1;
      end
      else
      begin
         case (phase)
            ks10ClockPkg::T1:
               phase <= ks10ClockPkg::T2;
            ks10ClockPkg::T2:
               phase <= ks10ClockPkg::T3;
            ks10ClockPkg::T3:
               phase <= ks10ClockPkg::T4;
            ks10ClockPkg::T4:
            begin
               // Leaving T4 ends a rotation, so the system may run
               phase    <= ks10ClockPkg::T1;
               sysReset <= 1'b0;
            end
            default:
               phase <= ks10ClockPkg::T1;  // Resync
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/ks10ClockPkg.sv */
// Phases are one-hot codes rotated on a single clkT edge, not separate phase-shifted clocks
`default_nettype none

package ks10ClockPkg;

   // Phase vector, bit 1 is T1 and bit 4 is T4
   typedef logic [1:4] phaseT;

   //////////////////////////////
   // Phase codes
   //////////////////////////////

   // Exactly one bit set in every legal phase
   localparam phaseT T1 = 4'b1000;  // Arbitration
   localparam phaseT T2 = 4'b0100;  // Address and data settle
   localparam phaseT T3 = 4'b0010;  // Memory access
   localparam phaseT T4 = 4'b0001;  // Acknowledge

endpackage

`default_nettype wire

/* source/ks10BusPkg.sv */
// Bus word and address widths are fixed; NumMasters must stay within 2..4, MemWords a power of two
`default_nettype none

package ks10BusPkg;

   //////////////////////////////
   // Data path
   //////////////////////////////

   localparam int WordWidth = 36;   // One KS10 word

   typedef logic [WordWidth-1:0] busWordT;

   //////////////////////////////
   // Addressing
   //////////////////////////////

   // Physical address as seen on the backplane
   localparam int AddrWidth = 20;

   typedef logic [AddrWidth-1:0] busAddrT;

   //////////////////////////////
   // Default system size
   //////////////////////////////

   localparam int DefNumMasters = 3;     // CPU, console, IO bridge
   localparam int DefMemWords   = 1024;  // Small array, addresses above alias

endpackage

`default_nettype wire
